//--- fpu_ss_pkg.sv
// FPU subsystem package
// Shared widths, opcode encodings and the operation set of the
// non-computational single-precision unit

package fpu_ss_pkg;

  // Data and control widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  xid_t;

  localparam int unsigned NUM_FPR         = 32;
  localparam int unsigned LOAD_FIFO_DEPTH = 3;

  // Load FIFO pointer and occupancy
  typedef logic [$clog2(LOAD_FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(LOAD_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // --------------------
  // Encodings
  // --------------------
  localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

  localparam logic [6:0] F7_SGNJ   = 7'b0010000;
  localparam logic [6:0] F7_MINMAX = 7'b0010100;
  localparam logic [6:0] F7_MV_X_W = 7'b1110000;
  localparam logic [6:0] F7_MV_W_X = 7'b1111000;

  // Word width for FLW and FSW
  localparam logic [2:0] FUNCT3_W = 3'b010;

  localparam word_t CANONICAL_NAN = 32'h7FC0_0000;

  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MIN,
    OP_MAX,
    OP_MV_X_W,
    OP_MV_W_X
  } fp_op_e;

endpackage

//--- fpu_ss_decoder.sv
// Offload instruction decoder
// Classifies a single-precision instruction into compute, load or store,
// and extracts register fields and the sign-extended memory immediate

module fpu_ss_decoder
  import fpu_ss_pkg::*;
(
  input  instr_t    instr_i,
  output logic      accept_o,
  output logic      is_load_o,
  output logic      is_store_o,
  output logic      is_compute_o,
  output logic      rd_is_fp_o,
  output fp_op_e    op_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output word_t     imm_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  reg_addr_t  rs1_f;
  reg_addr_t  rs2_f;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_f  = instr_i[19:15];
  assign rs2_f  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  // Fields that are not FP reads alias to rd, which is checked anyway
  always_comb begin
    accept_o     = 1'b0;
    is_load_o    = 1'b0;
    is_store_o   = 1'b0;
    is_compute_o = 1'b0;
    rd_is_fp_o   = 1'b0;
    op_o         = OP_SGNJ;
    rs1_o        = rs1_f;
    rs2_o        = rs2_f;
    imm_o        = {{20{instr_i[31]}}, instr_i[31:20]};

    unique case (opcode)
      OPC_OP_FP: begin
        unique case (funct7)
          F7_SGNJ: begin
            if (funct3 <= 3'b010) begin
              accept_o     = 1'b1;
              is_compute_o = 1'b1;
              rd_is_fp_o   = 1'b1;
              op_o         = (funct3 == 3'b000) ? OP_SGNJ :
                             (funct3 == 3'b001) ? OP_SGNJN : OP_SGNJX;
            end
          end
          F7_MINMAX: begin
            if (funct3[2:1] == 2'b00) begin
              accept_o     = 1'b1;
              is_compute_o = 1'b1;
              rd_is_fp_o   = 1'b1;
              op_o         = funct3[0] ? OP_MAX : OP_MIN;
            end
          end
          F7_MV_X_W: begin
            if (rs2_f == '0 && funct3 == 3'b000) begin
              accept_o     = 1'b1;
              is_compute_o = 1'b1;
              op_o         = OP_MV_X_W;
              rs2_o        = rs1_f;
            end
          end
          F7_MV_W_X: begin
            // rs1 is an integer operand here
            if (rs2_f == '0 && funct3 == 3'b000) begin
              accept_o     = 1'b1;
              is_compute_o = 1'b1;
              rd_is_fp_o   = 1'b1;
              op_o         = OP_MV_W_X;
              rs1_o        = rd_o;
              rs2_o        = rd_o;
            end
          end
          default: ;
        endcase
      end
      OPC_LOAD_FP: begin
        if (funct3 == FUNCT3_W) begin
          accept_o   = 1'b1;
          is_load_o  = 1'b1;
          rd_is_fp_o = 1'b1;
          rs1_o      = rd_o;
          rs2_o      = rd_o;
        end
      end
      OPC_STORE_FP: begin
        if (funct3 == FUNCT3_W) begin
          accept_o   = 1'b1;
          is_store_o = 1'b1;
          rs1_o      = rs2_f;
          imm_o      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        end
      end
      default: ;
    endcase
  end

endmodule

//--- fpu_ss_regfile.sv
// Floating-point register file
// 32 words, two read ports and one write port with write-through

module fpu_ss_regfile
  import fpu_ss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  word_t regs_q [NUM_FPR];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Same-cycle write is visible on both read ports
  assign rdata_a_o = (we_i && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
  assign rdata_b_o = (we_i && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];

  a_waddr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> !$isunknown(waddr_i));

endmodule

//--- fpu_ss_noncomp.sv
// Non-computational FP unit
// Sign injection, min/max and register moves, one output register stage

module fpu_ss_noncomp
  import fpu_ss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      in_valid_i,
  input  fp_op_e    op_i,
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  word_t     int_op_i,
  input  reg_addr_t rd_i,
  input  xid_t      id_i,
  input  logic      rd_is_fp_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  output word_t     out_result_o,
  output reg_addr_t out_rd_o,
  output xid_t      out_id_o,
  output logic      out_rd_is_fp_o,
  input  logic      out_ready_i
);

  function automatic logic is_nan(word_t w);
    return (w[30:23] == 8'hFF) && (w[22:0] != '0);
  endfunction

  logic  a_nan;
  logic  b_nan;
  logic  a_lt_b;
  word_t result;

  assign a_nan = is_nan(op_a_i);
  assign b_nan = is_nan(op_b_i);

  // Sign-magnitude compare, -0 sorts below +0
  always_comb begin
    if (op_a_i[31] != op_b_i[31]) begin
      a_lt_b = op_a_i[31];
    end else if (op_a_i[31]) begin
      a_lt_b = op_a_i[30:0] > op_b_i[30:0];
    end else begin
      a_lt_b = op_a_i[30:0] < op_b_i[30:0];
    end
  end

  always_comb begin
    unique case (op_i)
      OP_SGNJ:   result = {op_b_i[31], op_a_i[30:0]};
      OP_SGNJN:  result = {~op_b_i[31], op_a_i[30:0]};
      OP_SGNJX:  result = {op_a_i[31] ^ op_b_i[31], op_a_i[30:0]};
      OP_MIN, OP_MAX: begin
        if (a_nan && b_nan) begin
          result = CANONICAL_NAN;
        end else if (a_nan) begin
          result = op_b_i;
        end else if (b_nan) begin
          result = op_a_i;
        end else begin
          result = (a_lt_b ^ (op_i == OP_MAX)) ? op_a_i : op_b_i;
        end
      end
      OP_MV_X_W: result = op_a_i;
      OP_MV_W_X: result = int_op_i;
      default:   result = '0;
    endcase
  end

  // Output register takes a new op when empty or draining
  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      out_result_o   <= result;
      out_rd_o       <= rd_i;
      out_id_o       <= id_i;
      out_rd_is_fp_o <= rd_is_fp_i;
    end
  end

  a_no_issue_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(in_valid_i && !in_ready_o));

endmodule

//--- fpu_ss_load_fifo.sv
// Pending-load FIFO
// Keeps destination registers of outstanding FLW requests in issue order

module fpu_ss_load_fifo
  import fpu_ss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  reg_addr_t push_rd_i,
  input  logic      pop_i,
  output logic      full_o,
  output reg_addr_t head_rd_o
);

  reg_addr_t entries_q [LOAD_FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;

  assign full_o    = count_q == fifo_cnt_t'(LOAD_FIFO_DEPTH);
  assign head_rd_o = entries_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_t'(LOAD_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_t'(LOAD_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count unchanged
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries_q[wr_ptr_q] <= push_rd_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> count_q != '0);

endmodule

//--- fpu_ss_controller.sv
// FPU subsystem controller
// Scoreboard, issue handshake, memory and unit steering,
// write-port arbitration and result channel valid

module fpu_ss_controller
  import fpu_ss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      x_issue_valid_i,
  input  logic      accept_i,
  input  logic      is_load_i,
  input  logic      is_store_i,
  input  logic      is_compute_i,
  input  logic      rd_is_fp_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  logic      x_mem_ready_i,
  input  logic      fifo_full_i,
  input  logic      x_mem_result_valid_i,
  input  reg_addr_t head_rd_i,
  input  logic      unit_in_ready_i,
  input  logic      unit_out_valid_i,
  input  logic      unit_out_rd_is_fp_i,
  input  reg_addr_t unit_out_rd_i,
  input  logic      x_result_ready_i,
  output logic      x_issue_ready_o,
  output logic      x_mem_valid_o,
  output logic      fifo_push_o,
  output logic      fifo_pop_o,
  output logic      unit_in_valid_o,
  output logic      unit_out_ready_o,
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_wsel_load_o,
  output logic      x_result_valid_o
);

  logic [NUM_FPR-1:0] scoreboard_q;
  logic [NUM_FPR-1:0] busy;
  logic [NUM_FPR-1:0] clr_mask;
  logic [NUM_FPR-1:0] set_mask;
  logic               is_mem;
  logic               dep;
  logic               issue_fire;

  // --------------------
  // Write port
  // --------------------
  // Load data wins, the unit result waits a cycle
  assign fifo_pop_o       = x_mem_result_valid_i;
  assign rf_wsel_load_o   = x_mem_result_valid_i;
  assign rf_we_o          = x_mem_result_valid_i || (unit_out_valid_i && unit_out_rd_is_fp_i);
  assign rf_waddr_o       = x_mem_result_valid_i ? head_rd_i : unit_out_rd_i;
  assign unit_out_ready_o = unit_out_rd_is_fp_i ? !x_mem_result_valid_i : x_result_ready_i;
  assign x_result_valid_o = unit_out_valid_i && !unit_out_rd_is_fp_i;

  // --------------------
  // Scoreboard
  // --------------------
  assign clr_mask = rf_we_o ? (NUM_FPR'(1) << rf_waddr_o) : '0;
  assign set_mask = (issue_fire && rd_is_fp_i) ? (NUM_FPR'(1) << rd_i) : '0;

  // A register written this cycle reads through the bypass
  assign busy = scoreboard_q & ~clr_mask;
  assign dep  = busy[rs1_i] || busy[rs2_i] || (rd_is_fp_i && busy[rd_i]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scoreboard_q <= '0;
    end else begin
      scoreboard_q <= (scoreboard_q & ~clr_mask) | set_mask;
    end
  end

  // --------------------
  // Issue
  // --------------------
  assign is_mem = is_load_i || is_store_i;

  always_comb begin
    x_issue_ready_o = 1'b1;
    if (accept_i) begin
      x_issue_ready_o = !dep
                        && (!is_compute_i || unit_in_ready_i)
                        && (!is_load_i || !fifo_full_i)
                        && (!is_mem || x_mem_ready_i);
    end
  end

  assign issue_fire      = x_issue_valid_i && x_issue_ready_o && accept_i;
  assign unit_in_valid_o = issue_fire && is_compute_i;
  assign x_mem_valid_o   = issue_fire && is_mem;
  assign fifo_push_o     = issue_fire && is_load_i;

  // Every FP write retires a register that was marked busy at issue
  a_write_was_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rf_we_o |-> scoreboard_q[rf_waddr_o]);

endmodule

//--- fpu_ss.sv
// FPU subsystem top level
// Offloaded single-precision sign injection, min/max, moves and FLW/FSW
// with a scoreboarded FP register file and valid/ready channels

module fpu_ss
  import fpu_ss_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  // Issue channel
  input  logic      x_issue_valid_i,
  output logic      x_issue_ready_o,
  input  instr_t    x_issue_instr_i,
  input  xid_t      x_issue_id_i,
  input  word_t     x_issue_rs0_i,
  input  word_t     x_issue_rs1_i,
  output logic      x_issue_accept_o,
  output logic      x_issue_writeback_o,
  output logic      x_issue_loadstore_o,

  // Memory request channel
  output logic      x_mem_valid_o,
  input  logic      x_mem_ready_i,
  output word_t     x_mem_addr_o,
  output logic      x_mem_we_o,
  output word_t     x_mem_wdata_o,
  output xid_t      x_mem_id_o,

  // Memory result channel
  input  logic      x_mem_result_valid_i,
  input  word_t     x_mem_result_rdata_i,

  // Result channel
  output logic      x_result_valid_o,
  input  logic      x_result_ready_i,
  output word_t     x_result_data_o,
  output reg_addr_t x_result_rd_o,
  output xid_t      x_result_id_o
);

  logic      accept, is_load, is_store, is_compute, rd_is_fp;
  fp_op_e    op;
  reg_addr_t rs1, rs2, rd;
  word_t     imm;
  word_t     rdata_a, rdata_b, rf_wdata;
  logic      rf_we, rf_wsel_load;
  reg_addr_t rf_waddr, head_rd;
  logic      fifo_push, fifo_pop, fifo_full;
  logic      unit_in_valid, unit_in_ready, unit_out_valid, unit_out_ready;
  logic      unit_out_rd_is_fp;
  word_t     unit_result;
  reg_addr_t unit_out_rd;
  xid_t      unit_out_id;

  // --------------------
  // Issue response
  // --------------------
  assign x_issue_accept_o    = accept;
  assign x_issue_writeback_o = is_compute && !rd_is_fp;
  assign x_issue_loadstore_o = is_load || is_store;

  // Memory request, wdata is FP rs2 through the bypass
  assign x_mem_addr_o  = x_issue_rs0_i + imm;
  assign x_mem_we_o    = is_store;
  assign x_mem_wdata_o = rdata_b;
  assign x_mem_id_o    = x_issue_id_i;

  assign rf_wdata = rf_wsel_load ? x_mem_result_rdata_i : unit_result;

  assign x_result_data_o = unit_result;
  assign x_result_rd_o   = unit_out_rd;
  assign x_result_id_o   = unit_out_id;

  fpu_ss_decoder fpu_ss_decoder_i (
    .instr_i(x_issue_instr_i), .accept_o(accept), .is_load_o(is_load),
    .is_store_o(is_store), .is_compute_o(is_compute), .rd_is_fp_o(rd_is_fp),
    .op_o(op), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm)
  );

  fpu_ss_regfile fpu_ss_regfile_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .raddr_a_i(rs1), .raddr_b_i(rs2), .waddr_i(rf_waddr),
    .wdata_i(rf_wdata), .we_i(rf_we),
    .rdata_a_o(rdata_a), .rdata_b_o(rdata_b)
  );

  fpu_ss_noncomp fpu_ss_noncomp_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .in_valid_i(unit_in_valid), .op_i(op),
    .op_a_i(rdata_a), .op_b_i(rdata_b), .int_op_i(x_issue_rs0_i),
    .rd_i(rd), .id_i(x_issue_id_i), .rd_is_fp_i(rd_is_fp),
    .in_ready_o(unit_in_ready), .out_valid_o(unit_out_valid),
    .out_result_o(unit_result), .out_rd_o(unit_out_rd), .out_id_o(unit_out_id),
    .out_rd_is_fp_o(unit_out_rd_is_fp), .out_ready_i(unit_out_ready)
  );

  fpu_ss_load_fifo fpu_ss_load_fifo_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_i(fifo_push), .push_rd_i(rd), .pop_i(fifo_pop),
    .full_o(fifo_full), .head_rd_o(head_rd)
  );

  fpu_ss_controller fpu_ss_controller_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .x_issue_valid_i(x_issue_valid_i),
    .accept_i(accept), .is_load_i(is_load), .is_store_i(is_store),
    .is_compute_i(is_compute), .rd_is_fp_i(rd_is_fp),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
    .x_mem_ready_i(x_mem_ready_i), .fifo_full_i(fifo_full),
    .x_mem_result_valid_i(x_mem_result_valid_i), .head_rd_i(head_rd),
    .unit_in_ready_i(unit_in_ready), .unit_out_valid_i(unit_out_valid),
    .unit_out_rd_is_fp_i(unit_out_rd_is_fp), .unit_out_rd_i(unit_out_rd),
    .x_result_ready_i(x_result_ready_i),
    .x_issue_ready_o(x_issue_ready_o), .x_mem_valid_o(x_mem_valid_o),
    .fifo_push_o(fifo_push), .fifo_pop_o(fifo_pop),
    .unit_in_valid_o(unit_in_valid), .unit_out_ready_o(unit_out_ready),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wsel_load_o(rf_wsel_load),
    .x_result_valid_o(x_result_valid_o)
  );

endmodule

//--- tb_fpu_ss.sv
// Testbench for the FPU subsystem
// Applies a table of offloaded instructions, checks the issue response,
// memory requests and integer results, with a simple memory responder

module tb_fpu_ss;

  // Instruction fields, encoded from the ISA
  localparam logic [6:0] SGNJ   = 7'b0010000;
  localparam logic [6:0] MINMAX = 7'b0010100;
  localparam logic [6:0] MVXW   = 7'b1110000;
  localparam logic [6:0] MVWX   = 7'b1111000;

  // Kind of response expected from an entry
  localparam int K_FP    = 0;
  localparam int K_INT   = 1;
  localparam int K_LOAD  = 2;
  localparam int K_STORE = 3;
  localparam int K_BAD   = 4;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        x_issue_valid_i, x_issue_ready_o;
  logic [31:0] x_issue_instr_i, x_issue_rs0_i, x_issue_rs1_i;
  logic [3:0]  x_issue_id_i;
  logic        x_issue_accept_o, x_issue_writeback_o, x_issue_loadstore_o;
  logic        x_mem_valid_o, x_mem_ready_i, x_mem_we_o;
  logic [31:0] x_mem_addr_o, x_mem_wdata_o;
  logic [3:0]  x_mem_id_o;
  logic        x_mem_result_valid_i;
  logic [31:0] x_mem_result_rdata_i;
  logic        x_result_valid_o, x_result_ready_i;
  logic [31:0] x_result_data_o;
  logic [4:0]  x_result_rd_o;
  logic [3:0]  x_result_id_o;

  // Stimulus table with one column per queue
  string       names [$];
  logic [31:0] instrs [$];
  logic [3:0]  ids [$];
  logic [31:0] rs0s [$];
  logic [31:0] rs1s [$];
  int          kinds [$];
  logic [31:0] exp_a [$];
  logic [31:0] exp_d [$];
  int          holds [$];

  logic [31:0] mem [64];
  logic [31:0] load_data_q [$];
  int          load_due_q [$];
  int          cycle_cnt = 0;
  integer      seed = 17;

  fpu_ss u_fpu_ss (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .x_issue_valid_i(x_issue_valid_i), .x_issue_ready_o(x_issue_ready_o),
    .x_issue_instr_i(x_issue_instr_i), .x_issue_id_i(x_issue_id_i),
    .x_issue_rs0_i(x_issue_rs0_i), .x_issue_rs1_i(x_issue_rs1_i),
    .x_issue_accept_o(x_issue_accept_o), .x_issue_writeback_o(x_issue_writeback_o),
    .x_issue_loadstore_o(x_issue_loadstore_o),
    .x_mem_valid_o(x_mem_valid_o), .x_mem_ready_i(x_mem_ready_i),
    .x_mem_addr_o(x_mem_addr_o), .x_mem_we_o(x_mem_we_o),
    .x_mem_wdata_o(x_mem_wdata_o), .x_mem_id_o(x_mem_id_o),
    .x_mem_result_valid_i(x_mem_result_valid_i),
    .x_mem_result_rdata_i(x_mem_result_rdata_i),
    .x_result_valid_o(x_result_valid_o), .x_result_ready_i(x_result_ready_i),
    .x_result_data_o(x_result_data_o), .x_result_rd_o(x_result_rd_o),
    .x_result_id_o(x_result_id_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 40 * names.size()) begin
      $display("Error: the run timed out after %0d cycles", cycle_cnt);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  function automatic logic [31:0] flw(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000111};
  endfunction

  function automatic logic [31:0] fsw(input logic [4:0] rs2, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100111};
  endfunction

  // Initial memory contents as a function of the word index
  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    return {8'h5A, 2'b00, idx, 2'b11, ~idx, 8'h3C};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h actual %h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_test(input string name, input logic [31:0] instr,
                          input logic [31:0] rs0, input logic [31:0] rs1, input int kind,
                          input logic [31:0] ea, input logic [31:0] ed, input int hold);
    ids.push_back(4'(names.size()));
    names.push_back(name);
    instrs.push_back(instr);
    rs0s.push_back(rs0);
    rs1s.push_back(rs1);
    kinds.push_back(kind);
    exp_a.push_back(ea);
    exp_d.push_back(ed);
    holds.push_back(hold);
  endtask

  task automatic build_table();
    // --------------------
    // Moves and sign injection
    add_test("mv_w_x f1", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd1), 32'h3F80_0000, 0, K_FP, 0, 0, 0);
    add_test("mv_x_w f1", rtype(MVXW, 5'd0, 5'd1, 3'd0, 5'd5), 0, 0, K_INT, 5, 32'h3F80_0000, 0);
    add_test("mv_w_x f2", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd2), 32'hC040_0000, 0, K_FP, 0, 0, 0);
    add_test("fsgnj", rtype(SGNJ, 5'd2, 5'd1, 3'd0, 5'd3), 0, 0, K_FP, 0, 0, 0);
    add_test("fsgnj rd", rtype(MVXW, 5'd0, 5'd3, 3'd0, 5'd6), 0, 0, K_INT, 6, 32'hBF80_0000, 0);
    add_test("fsgnjn", rtype(SGNJ, 5'd2, 5'd2, 3'd1, 5'd4), 0, 0, K_FP, 0, 0, 0);
    add_test("fsgnjn rd", rtype(MVXW, 5'd0, 5'd4, 3'd0, 5'd7), 0, 0, K_INT, 7, 32'h4040_0000, 0);
    // Two negative operands, so the XOR clears the sign
    add_test("fsgnjx", rtype(SGNJ, 5'd3, 5'd2, 3'd2, 5'd5), 0, 0, K_FP, 0, 0, 0);
    add_test("fsgnjx rd", rtype(MVXW, 5'd0, 5'd5, 3'd0, 5'd8), 0, 0, K_INT, 8, 32'h4040_0000, 0);
    // --------------------
    // Min and max, NaN and signed zero
    add_test("mv_w_x f6", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd6), 32'h7F80_0001, 0, K_FP, 0, 0, 0);
    add_test("mv_w_x f7", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd7), 32'h7FC0_0123, 0, K_FP, 0, 0, 0);
    add_test("mv_w_x f8", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd8), 32'h8000_0000, 0, K_FP, 0, 0, 0);
    add_test("mv_w_x f9", rtype(MVWX, 5'd0, 5'd10, 3'd0, 5'd9), 32'h0000_0000, 0, K_FP, 0, 0, 0);
    add_test("fmin nan a", rtype(MINMAX, 5'd1, 5'd6, 3'd0, 5'd10), 0, 0, K_FP, 0, 0, 0);
    add_test("fmin nan a rd", rtype(MVXW, 5'd0, 5'd10, 3'd0, 5'd9), 0, 0, K_INT, 9,
             32'h3F80_0000, 0);
    add_test("fmax nan b", rtype(MINMAX, 5'd7, 5'd2, 3'd1, 5'd11), 0, 0, K_FP, 0, 0, 0);
    add_test("fmax nan b rd", rtype(MVXW, 5'd0, 5'd11, 3'd0, 5'd10), 0, 0, K_INT, 10,
             32'hC040_0000, 0);
    add_test("fmin two nan", rtype(MINMAX, 5'd7, 5'd6, 3'd0, 5'd12), 0, 0, K_FP, 0, 0, 0);
    add_test("fmin two nan rd", rtype(MVXW, 5'd0, 5'd12, 3'd0, 5'd11), 0, 0, K_INT, 11,
             32'h7FC0_0000, 0);
    // Negative zero as the first operand in both orders
    add_test("fmin zeros", rtype(MINMAX, 5'd9, 5'd8, 3'd0, 5'd13), 0, 0, K_FP, 0, 0, 0);
    add_test("fmin zeros rd", rtype(MVXW, 5'd0, 5'd13, 3'd0, 5'd12), 0, 0, K_INT, 12,
             32'h8000_0000, 0);
    add_test("fmax zeros", rtype(MINMAX, 5'd9, 5'd8, 3'd1, 5'd14), 0, 0, K_FP, 0, 0, 0);
    add_test("fmax zeros rd", rtype(MVXW, 5'd0, 5'd14, 3'd0, 5'd13), 0, 0, K_INT, 13,
             32'h0000_0000, 0);
    // --------------------
    // Loads and stores where the dependent store waits on the scoreboard
    add_test("flw f16", flw(5'd16, 5'd11, 12'd8), 32'h40, 0, K_LOAD, 32'h48, 0, 0);
    add_test("fsw f16", fsw(5'd16, 5'd11, 12'd12), 32'h80, 0, K_STORE, 32'h8C,
             fill_word(6'd18), 0);
    add_test("flw f17", flw(5'd17, 5'd11, 12'hFFC), 32'h64, 0, K_LOAD, 32'h60, 0, 0);
    add_test("flw f17 rd", rtype(MVXW, 5'd0, 5'd17, 3'd0, 5'd14), 0, 0, K_INT, 14,
             fill_word(6'd24), 0);
    add_test("fsw f1", fsw(5'd1, 5'd11, 12'hFF8), 32'hA8, 0, K_STORE, 32'hA0,
             32'h3F80_0000, 0);
    add_test("flw f18", flw(5'd18, 5'd11, 12'd0), 32'hA0, 0, K_LOAD, 32'hA0, 0, 0);
    // Result channel stalled for several cycles
    add_test("flw f18 rd", rtype(MVXW, 5'd0, 5'd18, 3'd0, 5'd15), 0, 0, K_INT, 15,
             32'h3F80_0000, 5);
    // --------------------
    // Unsupported encodings
    add_test("fadd", rtype(7'b0000000, 5'd2, 5'd1, 3'd0, 5'd3), 32'h44, 32'h55, K_BAD, 0, 0, 0);
    add_test("addi", 32'h0000_0013, 32'h10, 32'h20, K_BAD, 0, 0, 0);
  endtask

  task automatic collect_result(input int n);
    string name;
    name = names[n];
    #10;
    while (!x_result_valid_o) begin
      @(negedge clk_i);
      #10;
    end
    check({name, " data"}, exp_d[n], x_result_data_o);
    check({name, " rd"}, exp_a[n], 32'(x_result_rd_o));
    check({name, " id"}, 32'(ids[n]), 32'(x_result_id_o));
    // Core not ready yet
    repeat (holds[n]) begin
      @(negedge clk_i);
      #10;
      check({name, " held valid"}, 32'd1, 32'(x_result_valid_o));
      check({name, " held data"}, exp_d[n], x_result_data_o);
    end
    @(negedge clk_i);
    x_result_ready_i = 1'b1;
    @(negedge clk_i);
    x_result_ready_i = 1'b0;
    #10;
    check({name, " single take"}, 32'd0, 32'(x_result_valid_o));
  endtask

  task automatic apply_test(input int n);
    string name;
    logic  is_mem;
    name   = names[n];
    is_mem = kinds[n] == K_LOAD || kinds[n] == K_STORE;
    @(negedge clk_i);
    x_issue_valid_i = 1'b1;
    x_issue_instr_i = instrs[n];
    x_issue_id_i    = ids[n];
    x_issue_rs0_i   = rs0s[n];
    x_issue_rs1_i   = rs1s[n];
    #10;
    while (!x_issue_ready_o) begin
      @(negedge clk_i);
      #10;
    end
    // Transfer happens on the coming edge
    check({name, " accept"}, 32'(kinds[n] != K_BAD), 32'(x_issue_accept_o));
    check({name, " writeback"}, 32'(kinds[n] == K_INT), 32'(x_issue_writeback_o));
    check({name, " loadstore"}, 32'(is_mem), 32'(x_issue_loadstore_o));
    check({name, " mem valid"}, 32'(is_mem), 32'(x_mem_valid_o));
    if (is_mem) begin
      check({name, " addr"}, exp_a[n], x_mem_addr_o);
      check({name, " we"}, 32'(kinds[n] == K_STORE), 32'(x_mem_we_o));
      check({name, " mem id"}, 32'(ids[n]), 32'(x_mem_id_o));
      if (kinds[n] == K_STORE) begin
        check({name, " wdata"}, exp_d[n], x_mem_wdata_o);
      end
    end
    @(negedge clk_i);
    x_issue_valid_i = 1'b0;
    if (kinds[n] == K_INT) begin
      collect_result(n);
    end else if (kinds[n] == K_BAD) begin
      #10;
      check({name, " no result"}, 32'd0, 32'(x_result_valid_o));
    end
  endtask

  // --------------------
  // Memory responder answering loads two cycles after the request
  initial begin
    x_mem_ready_i        = 1'b0;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_rdata_i = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(6'(i));
    end
    forever begin
      @(negedge clk_i);
      if (load_due_q.size() > 0 && load_due_q[0] <= cycle_cnt) begin
        x_mem_result_valid_i = 1'b1;
        x_mem_result_rdata_i = load_data_q.pop_front();
        void'(load_due_q.pop_front());
      end else begin
        x_mem_result_valid_i = 1'b0;
      end
      x_mem_ready_i = ($random(seed) & 3) != 0;
      #10;
      if (x_mem_valid_o && x_mem_ready_i) begin
        if (x_mem_we_o) begin
          mem[x_mem_addr_o[7:2]] = x_mem_wdata_o;
        end else begin
          load_data_q.push_back(mem[x_mem_addr_o[7:2]]);
          load_due_q.push_back(cycle_cnt + 2);
        end
      end
    end
  end

  initial begin
    rst_n_i          = 1'b0;
    x_issue_valid_i  = 1'b0;
    x_issue_instr_i  = '0;
    x_issue_id_i     = '0;
    x_issue_rs0_i    = '0;
    x_issue_rs1_i    = '0;
    x_result_ready_i = 1'b0;
    build_table();
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int n = 0; n < names.size(); n++) begin
      apply_test(n);
    end
    repeat (4) @(negedge clk_i);
    #10;
    if (load_due_q.size() != 0 || x_result_valid_o) begin
      $display("Error: loads or results still pending after the last test");
      $display("SIMULATION FAILED");
      $fatal(1);
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- verilog.f
fpu_ss_pkg.sv
fpu_ss_decoder.sv
fpu_ss_regfile.sv
fpu_ss_noncomp.sv
fpu_ss_load_fifo.sv
fpu_ss_controller.sv
fpu_ss.sv
tb_fpu_ss.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FPU subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fpu_ss -f verilog.f -o sim_fpu_ss

# The simulator exit status is masked by tee, the log decides
./obj_dir/sim_fpu_ss 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "No failure found in sim.log"
